/* pbkdf_stimulus.txt */
# flag (bit 0 loads the nonce before the job, bit 1 at its end), data3, data2, data1
# (hex, top word first), nonce the job runs with, nonce_out after the job
1 123456781b0404cb4f3a94e9e2b1c9d4 000000003f65fa7c8e1d9b2a6c0f4e8371a5d2b90c84e6f15b2d3a909ac7e14f 7f1c3b5a2e9d0846c3a1f27b94e05d18b6f2039c51d8a4e70d3c69f200000002 12345678 12345679
0 123456781b0404cb4f3a94e9e2b1c9d4 000000003f65fa7c8e1d9b2a6c0f4e8371a5d2b90c84e6f15b2d3a909ac7e14f 7f1c3b5a2e9d0846c3a1f27b94e05d18b6f2039c51d8a4e70d3c69f200000002 12345679 1234567a
2 deadbeef1a44b9f25a6b7c8d9eafb0c1 243f6a8885a308d313198a2e03707344a4093822299f31d0082efa98ec4e6c89 452821e638d01377be5466cf34e90c6cc0ac29b7c97c50dd3f84d5b500000001 1234567a deadbeef
0 deadbeef1a44b9f25a6b7c8d9eafb0c1 243f6a8885a308d313198a2e03707344a4093822299f31d0082efa98ec4e6c89 452821e638d01377be5466cf34e90c6cc0ac29b7c97c50dd3f84d5b500000001 deadbeef deadbef0
1 ffffffff4d3c2b1a0f1e2d3c8899aabb 0123456789abcdeffedcba98765432100123456789abcdeffedcba9876543210 b5470917c0ac29b7c97c50dd3f84d5b5b5470917b5470917c0ac29b700000003 ffffffff 00000000
3 ffffffff4d3c2b1a0f1e2d3c8899aabb 0123456789abcdeffedcba98765432100123456789abcdeffedcba9876543210 b5470917c0ac29b7c97c50dd3f84d5b5b5470917b5470917c0ac29b700000003 ffffffff ffffffff
0 ffffffff4d3c2b1a0f1e2d3c8899aabb 0123456789abcdeffedcba98765432100123456789abcdeffedcba9876543210 b5470917c0ac29b7c97c50dd3f84d5b5b5470917b5470917c0ac29b700000003 ffffffff 00000000

/* compile.f */
+incdir+.
pbkdf_pkg.sv
sha256_compress.sv
pbkdf_sequencer.sv
pbkdf_engine.sv
pbkdf_engine_sva.sv
pbkdf_engine_tb.sv

/* Makefile */
TOP := pbkdf_engine_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

obj_dir/V$(TOP): compile.f $(wildcard *.sv) $(wildcard *.svh) pbkdf_stimulus.txt
	verilator --binary --assert -f compile.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* pbkdf_engine_tb.sv */
/*
 * Testbench for the PBKDF2-HMAC-SHA256 front end.
 * Jobs come from pbkdf_stimulus.txt. Each job's four slices are checked against a
 * software PBKDF2-HMAC-SHA256 model, and nonce_out against the file's values.
 */
`default_nettype none
`include "pbkdf_consts.svh"

module pbkdf_engine_tb
	import pbkdf_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int DRV_DLY = 2;			// Drive and sample point after posedge
	localparam int JOB_CYCLES = 13 * 70;	// Upper bound for one job

	localparam word_t RK [0:63] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	logic pbkdf_clk;
	logic reset;
	header_t header;
	logic loadnonce;
	logic start;
	x_out_t x_out;
	logic x_valid;
	logic busy;
	word_t nonce_out;

	logic [1:0] job_flag [$];			// Bit 0 load before, bit 1 load at end
	header_t job_hdr [$];
	word_t job_nonce [$];				// Nonce the job runs with
	word_t job_after [$];				// nonce_out once busy falls
	int num_jobs = 0;
	int checks = 0;
	int errors = 0;

	pbkdf_engine dut (
		.pbkdf_clk (pbkdf_clk),
		.reset     (reset),
		.header    (header),
		.loadnonce (loadnonce),
		.start     (start),
		.x_out     (x_out),
		.x_valid   (x_valid),
		.busy      (busy),
		.nonce_out (nonce_out)
	);

	initial begin
		pbkdf_clk = 1'b0;
		forever #(CLK_PERIOD / 2) pbkdf_clk = ~pbkdf_clk;
	end

	function automatic word_t ror(input word_t x, input int n);
		logic [63:0] xx;
		xx = {x, x} >> n;
		return xx[31:0];
	endfunction

	// One SHA-256 block over a full 64 word schedule
	function automatic hash_t sha_block(input hash_t h, input block_t m);
		word_t w [0:63];
		word_t v [0:7];
		word_t s0, s1, t1, t2;
		hash_t r;
		for (int t = 0; t < 16; t++)
			w[t] = m[t];
		for (int t = 16; t < 64; t++) begin
			s0 = ror(w[t-15], 7) ^ ror(w[t-15], 18) ^ (w[t-15] >> 3);
			s1 = ror(w[t-2], 17) ^ ror(w[t-2], 19) ^ (w[t-2] >> 10);
			w[t] = w[t-16] + s0 + w[t-7] + s1;
		end
		for (int i = 0; i < 8; i++)
			v[i] = h[i];
		for (int t = 0; t < `SHA256_ROUNDS; t++) begin
			s1 = ror(v[4], 6) ^ ror(v[4], 11) ^ ror(v[4], 25);
			t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + RK[t] + w[t];
			s0 = ror(v[0], 2) ^ ror(v[0], 13) ^ ror(v[0], 22);
			t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
			for (int i = 7; i > 0; i--)
				v[i] = v[i-1];
			v[4] = v[4] + t1;			// d + t1
			v[0] = t1 + t2;
		end
		for (int i = 0; i < 8; i++)
			r[i] = h[i] + v[i];
		return r;
	endfunction

	// PBKDF2 slice blk (1..4), header with nonce as password and salt
	function automatic hash_t pbkdf_slice(input header_t hdr, input word_t nonce, input int blk);
		hash_t key, ipad, opad, inner;
		block_t tail, ib, ob;
		tail = '0;
		tail[2:0] = hdr.data3[2:0];
		tail[3] = nonce;
		tail[4] = 32'h80000000;
		tail[15] = 32'd640;				// 80 byte message
		key = sha_block(sha_block(`SHA256_IV, {hdr.data2, hdr.data1}), tail);
		ipad = {32{`HMAC_IPAD_BYTE}};
		opad = {32{`HMAC_OPAD_BYTE}};
		ib = '0;
		ib[2:0] = hdr.data3[2:0];
		ib[3] = nonce;
		ib[4] = blk;					// Big endian block index
		ib[5] = 32'h80000000;
		ib[15] = 32'd1184;				// 64 + 80 + 4 bytes
		inner = sha_block(sha_block(sha_block(`SHA256_IV, {ipad, key ^ ipad}),
			{hdr.data2, hdr.data1}), ib);
		ob = '0;
		ob[7:0] = inner;
		ob[8] = 32'h80000000;
		ob[15] = 32'd768;				// 64 + 32 bytes
		return sha_block(sha_block(`SHA256_IV, {opad, key ^ opad}), ob);
	endfunction

	task automatic compare_value(input string name, input logic [255:0] got,
			input logic [255:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %0h expected %0h", name, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(posedge pbkdf_clk);
		#DRV_DLY;
	endtask

	task automatic run_job(input int j);
		int cyc;
		int pulses;
		int err0;
		header_t hdr;
		err0 = errors;
		hdr = job_hdr[j];
		header = hdr;
		if (job_flag[j][0]) begin
			loadnonce = 1'b1;
			next_cycle();
			loadnonce = 1'b0;
		end
		compare_value("nonce_out", 256'(nonce_out), 256'(job_nonce[j]));
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		compare_value("busy", 256'(busy), 256'(1'b1));
		pulses = 0;
		cyc = 0;
		while (cyc < JOB_CYCLES) begin
			next_cycle();
			cyc++;
			loadnonce = 1'b0;
			start = (cyc == 20);			// Stray start while busy
			if (!busy)
				break;
			if (x_valid) begin
				compare_value("x_out.index", 256'(x_out.index), 256'(pulses));
				compare_value("x_out.data", x_out.data,
					pbkdf_slice(hdr, job_nonce[j], pulses + 1));
				pulses++;
				if (pulses == 4) begin
					start = 1'b1;			// Stray start on the last busy edge
					if (job_flag[j][1])
						loadnonce = 1'b1;	// Lands on the increment edge
				end
			end
		end
		if (busy) begin
			$display("Job %0d still busy after %0d cycles", j, JOB_CYCLES);
			errors++;
		end
		compare_value("x_valid pulses", 256'(pulses), 256'(4));
		compare_value("nonce_out", 256'(nonce_out), 256'(job_after[j]));
		$display("job %0d nonce %h: %s", j, job_nonce[j], (errors == err0) ? "ok" : "failed");
	endtask

	initial begin
		int fd;
		int n;
		string line;
		logic [1:0] f;
		logic [127:0] d3;
		logic [255:0] d2, d1;
		word_t nv, av;
		reset = 1'b1;
		header = '0;
		loadnonce = 1'b0;
		start = 1'b0;
		fd = $fopen("pbkdf_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h", f, d3, d2, d1, nv, av);
					if (n == 6) begin
						job_flag.push_back(f);
						job_hdr.push_back({d3, d2, d1});
						job_nonce.push_back(nv);
						job_after.push_back(av);
					end else begin
						$display("Malformed stimulus line: %s", line);
						errors++;
					end
				end
			end
			$fclose(fd);
		end
		num_jobs = job_flag.size();
		repeat (5) next_cycle();
		reset = 1'b0;
		next_cycle();
		compare_value("busy", 256'(busy), 256'(0));
		compare_value("x_valid", 256'(x_valid), 256'(0));
		compare_value("nonce_out", 256'(nonce_out), 256'(0));
		$display("reset: %s", (errors == 0) ? "ok" : "failed");
		for (int j = 0; j < num_jobs; j++)
			run_job(j);
		if (dut.u_sva.fail_count != 0) begin
			$display("%0d assertion failures in the bound checks", dut.u_sva.fail_count);
			errors += dut.u_sva.fail_count;
		end
		$display("Summary: %0d jobs, %0d checks, %0d errors", num_jobs, checks, errors);
		if (errors == 0 && num_jobs > 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// Watchdog sized from the job count
	initial begin
		wait (num_jobs > 0);
		repeat (num_jobs * JOB_CYCLES + 200) @(posedge pbkdf_clk);
		$display("Watchdog expired before all jobs finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* pbkdf_engine_sva.sv */
/*
 * Concurrent checks on the pbkdf_engine ports, bound into the engine.
 * Covers x_valid against busy, slice index order and busy after reset.
 */
`default_nettype none

module pbkdf_engine_sva
	import pbkdf_pkg::*;
(
	input wire logic pbkdf_clk,
	input wire logic reset,
	input wire x_out_t x_out,
	input wire logic x_valid,
	input wire logic busy
);

	logic [1:0] last_idx;				// Index of the previous slice
	int fail_count = 0;

	always_ff @(posedge pbkdf_clk) begin
		if (reset)
			last_idx <= 2'd3;			// Next slice must be 0
		else if (x_valid)
			last_idx <= x_out.index;
	end

	valid_in_busy: assert property (@(posedge pbkdf_clk) disable iff (reset)
		x_valid |-> busy)
		else begin
			$error("x_valid high while busy is low");
			fail_count++;
		end

	index_order: assert property (@(posedge pbkdf_clk) disable iff (reset)
		x_valid |-> x_out.index == last_idx + 2'd1)
		else begin
			$error("x_out.index out of order");
			fail_count++;
		end

	idle_after_reset: assert property (@(posedge pbkdf_clk) reset |=> !busy)
		else begin
			$error("busy high in the cycle after reset");
			fail_count++;
		end

endmodule

bind pbkdf_engine pbkdf_engine_sva u_sva (
	.pbkdf_clk (pbkdf_clk),
	.reset     (reset),
	.x_out     (x_out),
	.x_valid   (x_valid),
	.busy      (busy)
);

`default_nettype wire

/* pbkdf_engine.sv */
/*
 * Top level of the PBKDF2-HMAC-SHA256 front end.
 * Pulse start to hash the header with the running nonce. Four x_valid
 * pulses then deliver the 128 byte result, one 256 bit slice each.
 */
`default_nettype none

module pbkdf_engine
	import pbkdf_pkg::*;
(
	input wire logic pbkdf_clk,
	input wire logic reset,
	input wire header_t header,
	input wire logic loadnonce,			// Take nonce from data3 top word
	input wire logic start,
	output x_out_t x_out,
	output logic x_valid,
	output logic busy,
	output word_t nonce_out
);

	logic hash_start;
	sha_req_t hash_req;
	hash_t hash_result;
	logic hash_done;

	pbkdf_sequencer u_seq (
		.pbkdf_clk   (pbkdf_clk),
		.reset       (reset),
		.start       (start),
		.loadnonce   (loadnonce),
		.header      (header),
		.hash_result (hash_result),
		.hash_done   (hash_done),
		.hash_start  (hash_start),
		.hash_req    (hash_req),
		.x_out       (x_out),
		.x_valid     (x_valid),
		.busy        (busy),
		.nonce_out   (nonce_out)
	);

	sha256_compress u_sha (
		.pbkdf_clk   (pbkdf_clk),
		.reset       (reset),
		.hash_start  (hash_start),
		.hash_req    (hash_req),
		.hash_result (hash_result),
		.hash_done   (hash_done)
	);

endmodule

`default_nettype wire

/* pbkdf_sequencer.sv */
/*
 * Control FSM for PBKDF2-HMAC-SHA256 over an 80 byte header.
 * Chains thirteen compressions (key hash, IPAD, OPAD and four block
 * iterations) and publishes each outer digest as one x_out word.
 * Owns the running nonce, which steps by one after every job.
 */
`default_nettype none
`include "pbkdf_consts.svh"

module pbkdf_sequencer
	import pbkdf_pkg::*;
(
	input wire logic pbkdf_clk,
	input wire logic reset,
	input wire logic start,
	input wire logic loadnonce,
	input wire header_t header,
	input wire hash_t hash_result,
	input wire logic hash_done,
	output logic hash_start,
	output sha_req_t hash_req,
	output x_out_t x_out,
	output logic x_valid,
	output logic busy,
	output word_t nonce_out
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_KEY1,							// Header first 64 bytes
		S_KEY2,							// Header tail with nonce
		S_IPAD1,						// Key XOR IPAD
		S_IPAD2,						// Header as message
		S_OPAD,							// Key XOR OPAD
		S_INNER,						// Block iteration inner hash
		S_OUTER,						// Block iteration outer hash
		S_DONE
	} seq_state_t;

	localparam hash_t IPAD_KEY = {32{`HMAC_IPAD_BYTE}};
	localparam hash_t OPAD_KEY = {32{`HMAC_OPAD_BYTE}};

	seq_state_t state;
	hash_t khash;						// Key, the hash of the header
	hash_t ihash;						// IPAD midstate
	hash_t ohash;						// OPAD midstate
	logic [2:0] blk_cnt;				// Block index 1..4
	word_t nonce;

	// Last 16 header bytes behind the block index, then padding
	function automatic block_t iter_block(input logic [2:0] blk, input word_t n,
			input header_t hdr);
		return {`PAD_BLOCK_ITER, 29'd0, blk, n, hdr.data3[2:0]};
	endfunction

	assign nonce_out = nonce;

	always_ff @(posedge pbkdf_clk) begin
		hash_start <= 1'b0;				// Strobes default low
		x_valid <= 1'b0;
		case (state)
			S_IDLE: begin
				if (start) begin
					busy <= 1'b1;
					hash_req.chain <= `SHA256_IV;
					hash_req.msg <= {header.data2, header.data1};
					hash_start <= 1'b1;
					state <= S_KEY1;
				end
			end
			S_KEY1: begin
				if (hash_done) begin
					hash_req.chain <= hash_result;
					hash_req.msg <= {`PAD_HEADER_TAIL, nonce, header.data3[2:0]};
					hash_start <= 1'b1;
					state <= S_KEY2;
				end
			end
			S_KEY2: begin
				if (hash_done) begin
					khash <= hash_result;				// Kept for the OPAD block
					hash_req.chain <= `SHA256_IV;
					hash_req.msg <= {IPAD_KEY, hash_result ^ IPAD_KEY};
					hash_start <= 1'b1;
					state <= S_IPAD1;
				end
			end
			S_IPAD1: begin
				if (hash_done) begin
					hash_req.chain <= hash_result;
					hash_req.msg <= {header.data2, header.data1};	// Header as salt
					hash_start <= 1'b1;
					state <= S_IPAD2;
				end
			end
			S_IPAD2: begin
				if (hash_done) begin
					ihash <= hash_result;
					hash_req.chain <= `SHA256_IV;
					hash_req.msg <= {OPAD_KEY, khash ^ OPAD_KEY};
					hash_start <= 1'b1;
					state <= S_OPAD;
				end
			end
			S_OPAD: begin
				if (hash_done) begin
					ohash <= hash_result;
					hash_req.chain <= ihash;			// First block iteration
					hash_req.msg <= iter_block(3'd1, nonce, header);
					blk_cnt <= 3'd1;
					hash_start <= 1'b1;
					state <= S_INNER;
				end
			end
			S_INNER: begin
				if (hash_done) begin
					hash_req.chain <= ohash;
					hash_req.msg <= {`PAD_OUTER, hash_result};
					hash_start <= 1'b1;
					state <= S_OUTER;
				end
			end
			S_OUTER: begin
				if (hash_done) begin
					x_valid <= 1'b1;					// Publish this slice
					x_out.index <= blk_cnt[1:0] - 2'd1;
					x_out.data <= hash_result;
					if (blk_cnt == 3'd4) begin
						state <= S_DONE;
					end else begin
						hash_req.chain <= ihash;
						hash_req.msg <= iter_block(blk_cnt + 3'd1, nonce, header);
						blk_cnt <= blk_cnt + 3'd1;
						hash_start <= 1'b1;
						state <= S_INNER;
					end
				end
			end
			S_DONE: begin
				busy <= 1'b0;
				nonce <= nonce + 32'd1;					// Next job's nonce
				state <= S_IDLE;
			end
			default: state <= S_IDLE;
		endcase

		// Load wins over the end-of-job increment
		if (loadnonce)
			nonce <= header.data3[3];

		if (reset) begin
			state <= S_IDLE;
			busy <= 1'b0;
			hash_start <= 1'b0;
			x_valid <= 1'b0;
			blk_cnt <= 3'd0;
			nonce <= 32'd0;
		end
	end

endmodule

`default_nettype wire

/* sha256_compress.sv */
/*
 * Looping SHA-256 compressor, one round per clock.
 * A hash_start strobe captures hash_req. hash_done pulses 66 cycles later
 * with hash_result valid, which then holds until the next start.
 */
`default_nettype none
`include "pbkdf_consts.svh"

module sha256_compress
	import pbkdf_pkg::*;
(
	input wire logic pbkdf_clk,
	input wire logic reset,
	input wire logic hash_start,
	input wire sha_req_t hash_req,
	output hash_t hash_result,
	output logic hash_done
);

	typedef enum logic [1:0] {
		C_IDLE,
		C_ROUND,
		C_ADD
	} comp_state_t;

	localparam word_t K [0:63] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	comp_state_t cstate;
	logic [5:0] rnd;					// Current round
	logic done;
	hash_t init;						// Chaining input, kept for the final add
	hash_t st;							// Working vars, a in word 0 .. h in word 7
	block_t w;							// Schedule window, W[t] in word 0
	word_t ch, maj, t1, t2, w_next;

	function automatic word_t rotr(input word_t x, input int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic word_t bsig0(input word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t bsig1(input word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic word_t ssig0(input word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t ssig1(input word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	assign ch = (st[4] & st[5]) ^ (~st[4] & st[6]);				// Choose on e
	assign maj = (st[0] & st[1]) ^ (st[0] & st[2]) ^ (st[1] & st[2]);
	assign t1 = st[7] + bsig1(st[4]) + ch + K[rnd] + w[0];
	assign t2 = bsig0(st[0]) + maj;
	assign w_next = ssig1(w[14]) + w[9] + ssig0(w[1]) + w[0];	// W[t+16]

	always_ff @(posedge pbkdf_clk) begin
		done <= 1'b0;
		case (cstate)
			C_IDLE: begin
				if (hash_start) begin					// Load cycle
					init <= hash_req.chain;
					st <= hash_req.chain;
					w <= hash_req.msg;
					rnd <= 6'd0;
					cstate <= C_ROUND;
				end
			end
			C_ROUND: begin
				st <= {st[6], st[5], st[4], st[3] + t1, st[2], st[1], st[0], t1 + t2};
				w <= {w_next, w[15:1]};					// Slide window by one word
				rnd <= rnd + 6'd1;
				if (rnd == 6'(`SHA256_ROUNDS - 1))
					cstate <= C_ADD;
			end
			C_ADD: begin
				for (int i = 0; i < 8; i++)
					st[i] <= st[i] + init[i];			// Feed forward
				done <= 1'b1;
				cstate <= C_IDLE;
			end
			default: cstate <= C_IDLE;
		endcase
		if (reset) begin
			cstate <= C_IDLE;
			rnd <= 6'd0;
			done <= 1'b0;
		end
	end

	assign hash_result = st;			// Stable until the next load
	assign hash_done = done;

endmodule

`default_nettype wire

/* pbkdf_pkg.sv */
/*
 * Shared types of the PBKDF2-HMAC-SHA256 front end.
 * Word 0 of every multi-word type sits in the least significant bits.
 * Modules pull these in with a wildcard import in their header.
 */
`default_nettype none

package pbkdf_pkg;

	typedef logic [31:0] word_t;		// One SHA word
	typedef word_t [7:0] hash_t;		// State or digest, H0 lowest
	typedef word_t [15:0] block_t;		// Message block, W0 lowest

	// 80 byte block header, nonce in data3[3]
	typedef struct packed {
		word_t [3:0] data3;
		word_t [7:0] data2;
		word_t [7:0] data1;
	} header_t;

	// One compression request
	typedef struct packed {
		hash_t chain;					// Chaining state
		block_t msg;					// Message block
	} sha_req_t;

	// One 256 bit slice of the 128 byte result
	typedef struct packed {
		logic [1:0] index;				// Slice number 0..3
		hash_t data;
	} x_out_t;

endpackage

`default_nettype wire

/* pbkdf_consts.svh */
/*
 * Fixed constants for the PBKDF2-HMAC-SHA256 front end.
 * Include after the nettype directive in any file that needs the SHA-256
 * start value, the HMAC pad bytes or the fixed padding words.
 */
`ifndef PBKDF_CONSTS_SVH
`define PBKDF_CONSTS_SVH

// SHA-256 start value with H0 in the low word
`define SHA256_IV {32'h5be0cd19, 32'h1f83d9ab, 32'h9b05688c, 32'h510e527f, \
	32'ha54ff53a, 32'h3c6ef372, 32'hbb67ae85, 32'h6a09e667}

`define SHA256_ROUNDS 64			// Rounds per compression

`define HMAC_IPAD_BYTE 8'h36		// Inner pad byte
`define HMAC_OPAD_BYTE 8'h5c		// Outer pad byte

// Tail of the 80 byte header, length 640 bits
`define PAD_HEADER_TAIL {32'h00000280, 320'd0, 32'h80000000}

// After block index, nonce and data3 low words, length 1184 bits
`define PAD_BLOCK_ITER {32'h000004a0, 288'd0, 32'h80000000}

// Outer hash over OPAD block plus 32 byte digest, length 768 bits
`define PAD_OUTER {32'h00000300, 192'd0, 32'h80000000}

`endif
